// File: logic/shfifo_pkg.sv
package shfifo_pkg;

  // pool geometry; the pool depth doubles as the initial push credit
  localparam int NUM_FIFOS  = 2;
  localparam int POOL_DEPTH = 8;
  localparam int DATA_W     = 8;

  localparam int FIFO_ID_W = 1;
  localparam int ADDR_W    = 3;
  // wide enough to hold POOL_DEPTH itself
  localparam int CNT_W     = 4;

  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [FIFO_ID_W-1:0] fifo_id_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [CNT_W-1:0]     cnt_t;

  // one accepted push on its way from the credit stage to the store
  typedef struct packed {
    fifo_id_t fifo_id;
    data_t    data;
  } push_entry_t;

endpackage

// File: logic/shfifo_rd_if.sv
interface shfifo_rd_if
  import shfifo_pkg::*;
();

  logic  [NUM_FIFOS-1:0] head_valid;
  data_t [NUM_FIFOS-1:0] head_data;
  logic  [NUM_FIFOS-1:0] deq;
  // pulses once per freed entry, a cycle after the free
  logic                  credit_return;

  modport store (
    output head_valid,
    output head_data,
    input  deq
  );

  modport pop (
    input  head_valid,
    input  head_data,
    output deq,
    output credit_return
  );

endinterface

// File: logic/shfifo_push_credit.sv
module shfifo_push_credit
  import shfifo_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,

  input  logic        push_valid,
  output logic        push_ready,
  input  fifo_id_t    push_fifo_id,
  input  data_t       push_data,

  input  logic        credit_return,

  output logic        wr_valid,
  output push_entry_t wr_entry
);

  cnt_t credit_cnt;
  cnt_t credit_nxt;
  logic push_fire;

  // ready only looks at the credit count, never at push_valid
  assign push_ready = (credit_cnt != '0);
  assign push_fire  = push_valid && push_ready;

  // a push and a returned credit in the same cycle cancel out
  always_comb begin
    credit_nxt = credit_cnt;
    if (push_fire) begin
      credit_nxt = credit_nxt - cnt_t'(1);
    end
    if (credit_return) begin
      credit_nxt = credit_nxt + cnt_t'(1);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_cnt <= cnt_t'(POOL_DEPTH);
      wr_valid   <= 1'b0;
    end else begin
      credit_cnt <= credit_nxt;
      wr_valid   <= push_fire;
    end
  end

  // payload only moves on an accepted push
  always_ff @(posedge clk) begin
    if (push_fire) begin
      wr_entry.fifo_id <= push_fifo_id;
      wr_entry.data    <= push_data;
    end
  end

endmodule

// File: logic/shfifo_linked_store.sv
module shfifo_linked_store
  import shfifo_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,

  input  logic        wr_valid,
  input  push_entry_t wr_entry,

  shfifo_rd_if.store  rd
);

  logic [POOL_DEPTH-1:0] free_map;
  data_t                 entry_data [POOL_DEPTH];
  addr_t                 next_ptr   [POOL_DEPTH];

  addr_t                 head     [NUM_FIFOS];
  addr_t                 tail     [NUM_FIFOS];
  cnt_t                  fifo_cnt [NUM_FIFOS];

  addr_t                 alloc_idx;
  logic [NUM_FIFOS-1:0]  wr_hit;

  // scanning from the top down leaves the lowest free index in alloc_idx
  always_comb begin
    alloc_idx = '0;
    for (int i = POOL_DEPTH - 1; i >= 0; i--) begin
      if (free_map[i]) begin
        alloc_idx = addr_t'(i);
      end
    end
  end

  always_comb begin
    for (int f = 0; f < NUM_FIFOS; f++) begin
      wr_hit[f] = wr_valid && (wr_entry.fifo_id == fifo_id_t'(f));
    end
  end

  // credits upstream guarantee a free bit whenever wr_valid is high
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      free_map <= '1;
    end else begin
      for (int f = 0; f < NUM_FIFOS; f++) begin
        if (rd.deq[f]) begin
          free_map[head[f]] <= 1'b1;
        end
      end
      // the allocated entry is never one being freed this cycle
      if (wr_valid) begin
        free_map[alloc_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int f = 0; f < NUM_FIFOS; f++) begin
        head[f]     <= '0;
        tail[f]     <= '0;
        fifo_cnt[f] <= '0;
      end
    end else begin
      for (int f = 0; f < NUM_FIFOS; f++) begin
        if (wr_hit[f]) begin
          tail[f] <= alloc_idx;
        end

        // when the only entry leaves as a new one arrives, the new one is
        // not linked yet, so the head has to take it straight from alloc
        if (wr_hit[f] && ((fifo_cnt[f] == '0) ||
                          (rd.deq[f] && (fifo_cnt[f] == cnt_t'(1))))) begin
          head[f] <= alloc_idx;
        end else if (rd.deq[f]) begin
          head[f] <= next_ptr[head[f]];
        end

        case ({wr_hit[f], rd.deq[f]})
          2'b10:   fifo_cnt[f] <= fifo_cnt[f] + cnt_t'(1);
          2'b01:   fifo_cnt[f] <= fifo_cnt[f] - cnt_t'(1);
          default: fifo_cnt[f] <= fifo_cnt[f];
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      entry_data[alloc_idx] <= wr_entry.data;
      for (int f = 0; f < NUM_FIFOS; f++) begin
        // link behind the old tail; an empty list has nothing to link to
        if (wr_hit[f] && (fifo_cnt[f] != '0)) begin
          next_ptr[tail[f]] <= alloc_idx;
        end
      end
    end
  end

  always_comb begin
    for (int f = 0; f < NUM_FIFOS; f++) begin
      rd.head_valid[f] = (fifo_cnt[f] != '0);
      rd.head_data[f]  = entry_data[head[f]];
    end
  end

endmodule

// File: logic/shfifo_pop_out.sv
module shfifo_pop_out
  import shfifo_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,

  output logic  [NUM_FIFOS-1:0] pop_valid,
  input  logic  [NUM_FIFOS-1:0] pop_ready,
  output data_t [NUM_FIFOS-1:0] pop_data,

  shfifo_rd_if.pop              rd
);

  cnt_t pend_cnt;
  cnt_t pops_now;
  cnt_t ret_total;
  logic credit_q;

  // each pop port shows its FIFO head directly
  assign pop_valid = rd.head_valid;
  assign pop_data  = rd.head_data;
  assign rd.deq    = pop_valid & pop_ready;

  always_comb begin
    pops_now = '0;
    for (int f = 0; f < NUM_FIFOS; f++) begin
      if (rd.deq[f]) begin
        pops_now = pops_now + cnt_t'(1);
      end
    end
    ret_total = pend_cnt + pops_now;
  end

  // the credit stage takes one credit per cycle, so simultaneous pops
  // queue up here and drain one pulse at a time
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pend_cnt <= '0;
      credit_q <= 1'b0;
    end else if (ret_total != '0) begin
      pend_cnt <= ret_total - cnt_t'(1);
      credit_q <= 1'b1;
    end else begin
      pend_cnt <= '0;
      credit_q <= 1'b0;
    end
  end

  assign rd.credit_return = credit_q;

endmodule

// File: logic/shfifo_top.sv
module shfifo_top
  import shfifo_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,

  input  logic                  push_valid,
  output logic                  push_ready,
  input  fifo_id_t              push_fifo_id,
  input  data_t                 push_data,

  output logic  [NUM_FIFOS-1:0] pop_valid,
  input  logic  [NUM_FIFOS-1:0] pop_ready,
  output data_t [NUM_FIFOS-1:0] pop_data
);

  logic        wr_valid;
  push_entry_t wr_entry;

  shfifo_rd_if rd_if_i ();

  shfifo_push_credit push_credit_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .push_valid    (push_valid),
    .push_ready    (push_ready),
    .push_fifo_id  (push_fifo_id),
    .push_data     (push_data),
    .credit_return (rd_if_i.credit_return),
    .wr_valid      (wr_valid),
    .wr_entry      (wr_entry)
  );

  shfifo_linked_store linked_store_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr_valid (wr_valid),
    .wr_entry (wr_entry),
    .rd       (rd_if_i.store)
  );

  shfifo_pop_out pop_out_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .pop_valid (pop_valid),
    .pop_ready (pop_ready),
    .pop_data  (pop_data),
    .rd        (rd_if_i.pop)
  );

endmodule

// File: dv/shfifo_tb_tests.svh
task automatic check_reset_state();
  int err_start;
  err_start = error_cnt;
  step();
  compare_flag("push_ready", last_push_ready, 1'b1);
  compare_flag("pop_valid[0]", last_pop_valid[0], 1'b0);
  compare_flag("pop_valid[1]", last_pop_valid[1], 1'b0);
  finish_test("reset state", err_start);
endtask

task automatic keep_fifo_order();
  int err_start;
  int accepted;
  int pops;
  int cyc;
  int first_cyc;
  err_start = error_cnt;
  accepted = 0;
  cyc = 0;
  first_cyc = -1;
  push_valid = 1'b1;
  push_fifo_id = '0;
  push_data = data_t'(rand_bits(DATA_W));
  while (accepted < ORDER_LEN && cyc < WAIT_LIMIT) begin
    step();
    cyc++;
    compare_flag("pop_valid[1]", last_pop_valid[1], 1'b0);
    // the first value shows up in the second cycle after its handshake
    if (first_cyc >= 0 && cyc - first_cyc == 1) begin
      compare_flag("pop_valid[0]", last_pop_valid[0], 1'b0);
    end
    if (first_cyc >= 0 && cyc - first_cyc == 2) begin
      compare_flag("pop_valid[0]", last_pop_valid[0], 1'b1);
    end
    if (last_push_fire) begin
      if (first_cyc < 0) begin
        first_cyc = cyc;
      end
      accepted++;
      push_data = data_t'(rand_bits(DATA_W));
    end
  end
  push_valid = 1'b0;
  if (accepted < ORDER_LEN) begin
    $display("only %0d of %0d pushes were accepted in time", accepted, ORDER_LEN);
    error_cnt++;
  end
  pops = 0;
  cyc = 0;
  pop_ready = 2'b01;
  while (pops < accepted && cyc < WAIT_LIMIT) begin
    step();
    cyc++;
    compare_flag("pop_valid[1]", last_pop_valid[1], 1'b0);
    if (last_pop_fire[0]) begin
      pops++;
    end
  end
  pop_ready = '0;
  if (pops < accepted) begin
    $display("FIFO 0 gave %0d of %0d values before timing out", pops, accepted);
    error_cnt++;
  end
  step();
  compare_flag("pop_valid[0]", last_pop_valid[0], 1'b0);
  finish_test("fifo order", err_start);
endtask

task automatic run_independent_pops();
  int    err_start;
  int    accepted;
  int    pops;
  int    cyc;
  data_t fifo1_head;
  logic  have_head;
  err_start = error_cnt;
  accepted = 0;
  cyc = 0;
  have_head = 1'b0;
  fifo1_head = '0;
  push_valid = 1'b1;
  push_fifo_id = '0;
  push_data = data_t'(rand_bits(DATA_W));
  while (accepted < 2 * PER_FIFO && cyc < WAIT_LIMIT) begin
    step();
    cyc++;
    if (last_push_fire) begin
      if (push_fifo_id == fifo_id_t'(1) && !have_head) begin
        fifo1_head = push_data;
        have_head = 1'b1;
      end
      accepted++;
      push_fifo_id = ~push_fifo_id;
      push_data = data_t'(rand_bits(DATA_W));
    end
  end
  push_valid = 1'b0;
  if (accepted < 2 * PER_FIFO) begin
    $display("only %0d of %0d pushes were accepted in time", accepted, 2 * PER_FIFO);
    error_cnt++;
  end

  // FIFO 1 sits stalled while FIFO 0 drains
  pops = 0;
  cyc = 0;
  pop_ready = 2'b01;
  while (pops < PER_FIFO && cyc < WAIT_LIMIT) begin
    step();
    cyc++;
    compare_flag("pop_valid[1]", last_pop_valid[1], 1'b1);
    compare_data("pop_data[1]", last_pop_data[1], fifo1_head);
    if (last_pop_fire[0]) begin
      pops++;
    end
  end
  if (pops < PER_FIFO) begin
    $display("FIFO 0 stopped draining while FIFO 1 was stalled");
    error_cnt++;
  end

  pops = 0;
  cyc = 0;
  pop_ready = 2'b10;
  while (pops < PER_FIFO && cyc < WAIT_LIMIT) begin
    step();
    cyc++;
    compare_flag("pop_valid[0]", last_pop_valid[0], 1'b0);
    if (last_pop_fire[1]) begin
      pops++;
    end
  end
  pop_ready = '0;
  if (pops < PER_FIFO) begin
    $display("FIFO 1 stopped draining after FIFO 0 was empty");
    error_cnt++;
  end
  step();
  compare_flag("pop_valid[0]", last_pop_valid[0], 1'b0);
  compare_flag("pop_valid[1]", last_pop_valid[1], 1'b0);
  finish_test("independent pops", err_start);
endtask

task automatic exhaust_credits();
  int err_start;
  int accepted;
  err_start = error_cnt;
  fill_pool(accepted);
  compare_count("accepted pushes", cnt_t'(accepted), cnt_t'(POOL_DEPTH));
  // alternating pushes leave entries waiting in both FIFOs
  compare_flag("pop_valid[0]", last_pop_valid[0], 1'b1);
  compare_flag("pop_valid[1]", last_pop_valid[1], 1'b1);
  repeat (2) begin
    step();
    compare_flag("push_ready", last_push_ready, 1'b0);
  end
  push_valid = 1'b0;
  pop_ready = 2'b01;
  step();
  compare_flag("pop_valid[0]", last_pop_valid[0], 1'b1);
  pop_ready = '0;
  // the freed credit reaches push_ready two edges after the pop
  step();
  compare_flag("push_ready", last_push_ready, 1'b0);
  step();
  compare_flag("push_ready", last_push_ready, 1'b1);
  drain_all();
  finish_test("credit exhaustion", err_start);
endtask

task automatic run_random_traffic();
  int err_start;
  int accepted;
  err_start = error_cnt;
  for (int c = 0; c < RANDOM_CYCLES; c++) begin
    push_valid = rand_bit();
    push_fifo_id = fifo_id_t'(rand_bits(FIFO_ID_W));
    push_data = data_t'(rand_bits(DATA_W));
    for (int f = 0; f < NUM_FIFOS; f++) begin
      pop_ready[f] = rand_bit();
    end
    step();
  end
  drain_all();
  // a lost credit would show up as a short refill
  fill_pool(accepted);
  push_valid = 1'b0;
  compare_count("accepted pushes", cnt_t'(accepted), cnt_t'(POOL_DEPTH));
  drain_all();
  step();
  compare_flag("push_ready", last_push_ready, 1'b1);
  finish_test("random traffic", err_start);
endtask

// File: dv/shfifo_tb.sv
module shfifo_tb
  import shfifo_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT    = 64;
  localparam int ORDER_LEN     = 5;
  localparam int PER_FIFO      = 3;
  localparam int RANDOM_CYCLES = 300;

  logic                  clk;
  logic                  arst_n;
  logic                  push_valid;
  logic                  push_ready;
  fifo_id_t              push_fifo_id;
  data_t                 push_data;
  logic  [NUM_FIFOS-1:0] pop_valid;
  logic  [NUM_FIFOS-1:0] pop_ready;
  data_t [NUM_FIFOS-1:0] pop_data;

  // reference model with one queue of expected values per FIFO
  data_t model_q [NUM_FIFOS][$];

  // values seen in the middle of the most recent cycle
  logic                  last_push_ready;
  logic                  last_push_fire;
  logic  [NUM_FIFOS-1:0] last_pop_valid;
  logic  [NUM_FIFOS-1:0] last_pop_fire;
  data_t [NUM_FIFOS-1:0] last_pop_data;

  logic [31:0] lfsr;
  int          error_cnt;
  int          pass_cnt;
  int          fail_cnt;

  shfifo_top dut_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .push_valid   (push_valid),
    .push_ready   (push_ready),
    .push_fifo_id (push_fifo_id),
    .push_data    (push_data),
    .pop_valid    (pop_valid),
    .pop_ready    (pop_ready),
    .pop_data     (pop_data)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // galois form of x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  task automatic compare_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      error_cnt++;
    end
  endtask

  task automatic compare_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      error_cnt++;
    end
  endtask

  task automatic compare_count(string name, cnt_t got, cnt_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      error_cnt++;
    end
  endtask

  // samples at the falling edge, tracks handshakes, returns just after the next rising edge
  task automatic step();
    data_t                 exp;
    logic  [NUM_FIFOS-1:0] prev_valid;
    logic  [NUM_FIFOS-1:0] prev_fire;
    data_t [NUM_FIFOS-1:0] prev_data;
    prev_valid = last_pop_valid;
    prev_fire  = last_pop_fire;
    prev_data  = last_pop_data;
    @(negedge clk);
    last_push_ready = push_ready;
    last_push_fire  = push_valid && push_ready;
    last_pop_valid  = pop_valid;
    last_pop_fire   = pop_valid & pop_ready;
    last_pop_data   = pop_data;
    if (last_push_fire) begin
      model_q[push_fifo_id].push_back(push_data);
    end
    for (int f = 0; f < NUM_FIFOS; f++) begin
      // a stalled head has to stay put until it is taken
      if (prev_valid[f] && !prev_fire[f]) begin
        compare_flag($sformatf("pop_valid[%0d]", f), pop_valid[f], 1'b1);
        compare_data($sformatf("pop_data[%0d]", f), pop_data[f], prev_data[f]);
      end
      if (last_pop_fire[f]) begin
        if (model_q[f].size() == 0) begin
          $display("FIFO %0d delivered a value while nothing was left to pop", f);
          error_cnt++;
        end else begin
          exp = model_q[f].pop_front();
          compare_data($sformatf("pop_data[%0d]", f), pop_data[f], exp);
        end
      end
    end
    @(posedge clk);
    #1;
  endtask

  task automatic drain_all();
    int   cyc;
    logic busy;
    cyc = 0;
    busy = 1'b1;
    push_valid = 1'b0;
    pop_ready = '1;
    while (busy && cyc < WAIT_LIMIT) begin
      step();
      cyc++;
      busy = (last_pop_valid != '0) || (model_q[0].size() != 0) || (model_q[1].size() != 0);
    end
    pop_ready = '0;
    if (busy) begin
      $display("FIFOs did not drain within %0d cycles", WAIT_LIMIT);
      error_cnt++;
    end
  endtask

  // pushes with both pop ports stalled until push_ready drops and leaves push_valid high
  task automatic fill_pool(output int accepted);
    int cyc;
    accepted = 0;
    cyc = 0;
    pop_ready = '0;
    push_valid = 1'b1;
    push_fifo_id = '0;
    push_data = data_t'(rand_bits(DATA_W));
    last_push_ready = 1'b1;
    while (last_push_ready && cyc < WAIT_LIMIT) begin
      step();
      cyc++;
      if (last_push_fire) begin
        accepted++;
        push_fifo_id = ~push_fifo_id;
        push_data = data_t'(rand_bits(DATA_W));
      end
    end
    if (last_push_ready) begin
      $display("push_ready never dropped within %0d cycles", WAIT_LIMIT);
      error_cnt++;
    end
  endtask

  task automatic finish_test(string name, int err_start);
    if (error_cnt == err_start) begin
      $display("%s: ok", name);
      pass_cnt++;
    end else begin
      $display("%s: %0d errors", name, error_cnt - err_start);
      fail_cnt++;
    end
  endtask

  `include "shfifo_tb_tests.svh"

  initial begin
    lfsr = 32'hf6403f33;
    error_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    last_push_ready = 1'b0;
    last_push_fire = 1'b0;
    last_pop_valid = '0;
    last_pop_fire = '0;
    last_pop_data = '0;
    arst_n = 1'b0;
    push_valid = 1'b0;
    push_fifo_id = '0;
    push_data = '0;
    pop_ready = '0;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;

    check_reset_state();
    keep_fifo_order();
    run_independent_pops();
    exhaust_credits();
    run_random_traffic();

    $display("results: %0d ok, %0d failing", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && error_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+dv
logic/shfifo_pkg.sv
logic/shfifo_rd_if.sv
logic/shfifo_push_credit.sv
logic/shfifo_linked_store.sv
logic/shfifo_pop_out.sv
logic/shfifo_top.sv
dv/shfifo_tb.sv

// File: Bender.yml
package:
  name: shfifo

sources:
  - logic/shfifo_pkg.sv
  - logic/shfifo_rd_if.sv
  - logic/shfifo_push_credit.sv
  - logic/shfifo_linked_store.sv
  - logic/shfifo_pop_out.sv
  - logic/shfifo_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/shfifo_tb.sv
